/* compile.f */
hdl/pat_pkg.sv
hdl/pat_alu.sv
hdl/pat_data_mem.sv
hdl/pat_program_counter.sv
hdl/pat_decode.sv
hdl/pat_commit.sv
hdl/pat_top.sv
testbench/tb_clock_gen.sv
testbench/pat_tb.sv

/* hdl/pat_alu.sv */
`timescale 1ns/1ps

module pat_alu import pat_pkg::*; (
	input  logic [D_WIDTH-1:0] i_a,      // acc or selected field input
	input  logic [D_WIDTH-1:0] i_b,      // immediate or memory word
	input  alu_op_e            i_alu_op,
	output logic [D_WIDTH-1:0] o_y
);

	logic [2:0]         sh;              // shift distance
	logic [D_WIDTH-1:0] shl_y;
	logic [D_WIDTH-1:0] shlo_y;
	logic [D_WIDTH-1:0] shr_y;
	logic [D_WIDTH-1:0] asr_y;
	logic [D_WIDTH-1:0] fill_ones;       // low ones vacated by shlo
	logic [D_WIDTH-1:0] b_addsub;
	logic [D_WIDTH-1:0] addsub_y;

	assign sh = i_b[2:0];

	// ============================================================
	// shifter
	// ============================================================
	assign shl_y     = i_a << sh;
	assign fill_ones = ~({D_WIDTH{1'b1}} << sh);
	assign shlo_y    = shl_y | fill_ones;
	assign shr_y     = i_a >> sh;                     // logical
	assign asr_y     = D_WIDTH'($signed(i_a) >>> sh); // sign bit copied in

	// single adder for add and sub, mod 256
	assign b_addsub = (i_alu_op == ALU_SUB) ? ~i_b : i_b;
	assign addsub_y = i_a + b_addsub + D_WIDTH'(i_alu_op == ALU_SUB);

	// result select
	always_comb
	begin
		case (i_alu_op)
			ALU_OR:     o_y = i_a | i_b;
			ALU_AND:    o_y = i_a & i_b;
			ALU_NOT:    o_y = ~i_a;
			ALU_ADD:    o_y = addsub_y;
			ALU_SUB:    o_y = addsub_y;
			ALU_SHL:    o_y = shl_y;
			ALU_SHLO:   o_y = shlo_y;
			ALU_SHR:    o_y = shr_y;
			ALU_ASR:    o_y = asr_y;
			ALU_PASS_B: o_y = i_b;       // ldi, ldm
			default:    o_y = i_b;
		endcase
	end

endmodule

/* hdl/pat_commit.sv */
`timescale 1ns/1ps

module pat_commit import pat_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [D_WIDTH-1:0]        i_alu_y,
	input  cond_e                     i_cond,
	input  logic                      i_field_op,
	input  logic                      i_dest_acc,
	input  logic                      i_dest_field,
	input  logic                      i_dest_dmem,
	input  logic                      i_op_out,
	input  logic                      i_op_setb,
	input  logic                      i_op_test,
	input  logic                      i_op_mov,
	input  logic                      i_op_in,
	input  logic [D_WIDTH-1:0]        i_imm,
	input  logic [D_WIDTH-1:0]        i_field_in_low,
	input  logic [D_WIDTH-1:0]        i_field_in_high,
	input  logic [D_WIDTH-1:0]        i_inputs,
	output logic [D_WIDTH-1:0]        o_acc,
	output logic                      o_high_sel,     // 1 = high side buffer
	output logic                      o_dmem_we,
	output logic [DMEM_ADR_WIDTH-1:0] o_dmem_wadr,
	output logic [D_WIDTH-1:0]        o_dmem_wdata,
	output logic                      o_field_we_low,
	output logic                      o_field_we_high,
	output logic [D_WIDTH-1:0]        o_field_out,
	output logic [D_WIDTH-1:0]        o_outputs,
	output logic [BUFP_WIDTH-1:0]     o_bufp
);

	logic               z, n;           // flags, only touched by test
	logic               commit;         // condition met this cycle
	logic [D_WIDTH-1:0] field_sel;      // live field input on the selected side
	logic [D_WIDTH-1:0] result;
	logic [D_WIDTH-1:0] test_val;

	assign field_sel = o_high_sel ? i_field_in_high : i_field_in_low;

	// condition check against current flags
	always_comb
	begin
		case (i_cond)
			COND_NEG:  commit = n;
			COND_ZERO: commit = z;
			default:   commit = 1'b1; // codes 0 and 3
		endcase
	end

	assign result   = i_op_in ? i_inputs : i_alu_y;
	assign test_val = i_field_op ? field_sel : o_acc;

	// ============================================================
	// store path, written by the memory at this edge
	// ============================================================
	assign o_dmem_we    = commit && i_dest_dmem;
	assign o_dmem_wadr  = i_imm[DMEM_ADR_WIDTH-1:0];
	assign o_dmem_wdata = i_field_op ? field_sel : o_acc;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_acc           <= '0;
			z               <= 1'b0;
			n               <= 1'b0;
			o_bufp          <= '0;
			o_high_sel      <= 1'b0;
			o_outputs       <= '0;
			o_field_out     <= '0;
			o_field_we_low  <= 1'b0;
			o_field_we_high <= 1'b0;
		end
		else
		begin
			// enables are single-cycle pulses
			o_field_we_low  <= commit && i_dest_field && !o_high_sel;
			o_field_we_high <= commit && i_dest_field && o_high_sel;
			if (commit)
			begin
				if (i_dest_acc)
					o_acc <= i_op_mov ? field_sel : result;        // mov loads field into acc
				if (i_dest_field)
					o_field_out <= i_op_mov ? o_acc : result;      // mov writes acc out
				if (i_op_out)
					o_outputs <= o_acc;
				if (i_op_setb)
				begin
					o_bufp     <= i_imm[BUFP_WIDTH-1:0];
					o_high_sel <= i_imm[SETB_SIDE_BIT];
				end
				if (i_op_test)
				begin
					z <= (test_val == '0);
					n <= test_val[D_WIDTH-1];
				end
			end
		end
	end

endmodule

/* hdl/pat_data_mem.sv */
`timescale 1ns/1ps

module pat_data_mem import pat_pkg::*; (
	input  logic                      clk,
	input  logic [DMEM_ADR_WIDTH-1:0] i_radr,
	output logic [D_WIDTH-1:0]        o_rdata,
	input  logic                      i_we,
	input  logic [DMEM_ADR_WIDTH-1:0] i_wadr,
	input  logic [D_WIDTH-1:0]        i_wdata
);

	logic [D_WIDTH-1:0] mem [DMEM_DEPTH];

	// async read, a same-cycle write is not visible yet
	assign o_rdata = mem[i_radr];

	always_ff @(posedge clk)
	begin
		if (i_we)
			mem[i_wadr] <= i_wdata;
	end

endmodule

/* hdl/pat_decode.sv */
`timescale 1ns/1ps

module pat_decode import pat_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [I_WIDTH-1:0]        i_instruction,
	input  logic [D_WIDTH-1:0]        i_dmem_data,     // async read of o_dmem_adr
	output logic                      o_jump,
	output logic [D_WIDTH-1:0]        o_branch_offset,
	output logic [DMEM_ADR_WIDTH-1:0] o_dmem_adr,
	output alu_op_e                   o_alu_op,
	output logic [D_WIDTH-1:0]        o_alu_b,
	output cond_e                     o_cond,
	output logic                      o_field_op,
	output logic                      o_dest_acc,
	output logic                      o_dest_field,
	output logic                      o_dest_dmem,
	output logic                      o_op_out,
	output logic                      o_op_setb,
	output logic                      o_op_test,
	output logic                      o_op_mov,
	output logic                      o_op_in,
	output logic [D_WIDTH-1:0]        o_imm,
	output logic [FIELDP_WIDTH-1:0]   o_fieldp,
	output logic [FIELDP_WIDTH-1:0]   o_fieldwp
);

	logic [I_WIDTH-1:0] instr_d;             // D stage instruction register
	logic [D_WIDTH-1:0] imm8;
	logic [D_WIDTH-1:0] imm3_ext;
	logic               is_i8, is_i3;
	op8_e               op8;
	op3_e               op3;
	op0_e               op0;
	alu_op_e            alu_op_d;
	logic               dest_reg, src_dmem;  // writes acc/field ; B from memory
	logic               stm_d, bf_d, out_d, setb_d, test_d, mov_d, in_d;
	logic [FIELDP_WIDTH-1:0] fieldp_hist [FIELD_LATENCY];

	// ============================================================
	// D stage: field split and class decode
	// ============================================================
	assign imm8     = instr_d[F_IMM_MSB:F_IMM_LSB];
	assign imm3_ext = {{(D_WIDTH-(F_IMM3_MSB-F_IMM3_LSB+1)){1'b0}},
		instr_d[F_IMM3_MSB:F_IMM3_LSB]};
	assign op8 = op8_e'(instr_d[F_OP8_MSB:F_OP8_LSB]);
	assign op3 = op3_e'(instr_d[F_OP3_MSB:F_OP3_LSB]);
	assign op0 = op0_e'(instr_d[F_OP0_MSB:F_OP0_LSB]);

	assign is_i8 = (instr_d[F_OP8_MSB:F_OP8_LSB] != PREFIX);
	assign is_i3 = !is_i8 && (instr_d[F_OP3_MSB:F_OP3_LSB] != PREFIX); // else i0

	always_comb
	begin
		alu_op_d = ALU_PASS_B; // ld*, mov and in ignore the ALU
		dest_reg = 1'b0;
		src_dmem = 1'b0;
		stm_d    = 1'b0;
		bf_d     = 1'b0;
		out_d    = 1'b0;
		setb_d   = 1'b0;
		test_d   = 1'b0;
		mov_d    = 1'b0;
		in_d     = 1'b0;
		if (is_i8)
		begin
			case (op8)
				OP8_OR:   begin alu_op_d = ALU_OR;  dest_reg = 1'b1; end
				OP8_AND:  begin alu_op_d = ALU_AND; dest_reg = 1'b1; end
				OP8_ADD:  begin alu_op_d = ALU_ADD; dest_reg = 1'b1; end
				OP8_SUB:  begin alu_op_d = ALU_SUB; dest_reg = 1'b1; end
				OP8_ORM:  begin alu_op_d = ALU_OR;  dest_reg = 1'b1; src_dmem = 1'b1; end
				OP8_ANDM: begin alu_op_d = ALU_AND; dest_reg = 1'b1; src_dmem = 1'b1; end
				OP8_ADDM: begin alu_op_d = ALU_ADD; dest_reg = 1'b1; src_dmem = 1'b1; end
				OP8_SUBM: begin alu_op_d = ALU_SUB; dest_reg = 1'b1; src_dmem = 1'b1; end
				OP8_LDI:  dest_reg = 1'b1;                      // pass immediate
				OP8_LDM:  begin dest_reg = 1'b1; src_dmem = 1'b1; end
				OP8_STM:  stm_d = 1'b1;
				OP8_BF:   bf_d = 1'b1;
				default:  ;                                     // unused codes do nothing
			endcase
		end
		else if (is_i3)
		begin
			case (op3)
				OP3_SHL:  begin alu_op_d = ALU_SHL;  dest_reg = 1'b1; end
				OP3_SHLO: begin alu_op_d = ALU_SHLO; dest_reg = 1'b1; end
				OP3_SHR:  begin alu_op_d = ALU_SHR;  dest_reg = 1'b1; end
				OP3_ASR:  begin alu_op_d = ALU_ASR;  dest_reg = 1'b1; end
				OP3_IN:   begin in_d = 1'b1; dest_reg = 1'b1; end
				OP3_OUT:  out_d = 1'b1;
				OP3_SETB: setb_d = 1'b1;
				default:  ;
			endcase
		end
		else
		begin
			case (op0)
				OP0_NOT:  begin alu_op_d = ALU_NOT; dest_reg = 1'b1; end
				OP0_MOV:  begin mov_d = 1'b1; dest_reg = 1'b1; end // direction from field bit
				OP0_TEST: test_d = 1'b1;
				default:  ;                                          // nop
			endcase
		end
	end

	// branch and memory read act straight from the D register
	assign o_jump          = bf_d;
	assign o_branch_offset = imm8;
	assign o_dmem_adr      = imm8[DMEM_ADR_WIDTH-1:0];

	// ============================================================
	// D and E registers
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			instr_d      <= INSTR_NOP;
			o_alu_op     <= ALU_PASS_B;
			o_cond       <= COND_ALWAYS;
			o_field_op   <= 1'b0;
			o_dest_acc   <= 1'b0;
			o_dest_field <= 1'b0;
			o_dest_dmem  <= 1'b0;
			o_op_out     <= 1'b0;
			o_op_setb    <= 1'b0;
			o_op_test    <= 1'b0;
			o_op_mov     <= 1'b0;
			o_op_in      <= 1'b0;
		end
		else
		begin
			instr_d      <= i_instruction;
			o_alu_op     <= alu_op_d;
			o_cond       <= cond_e'(instr_d[F_COND_MSB:F_COND_LSB]);
			o_field_op   <= instr_d[F_FIELD_OP];
			o_dest_acc   <= dest_reg && !instr_d[F_FIELD_OP];
			o_dest_field <= dest_reg && instr_d[F_FIELD_OP];
			o_dest_dmem  <= stm_d;
			o_op_out     <= out_d;
			o_op_setb    <= setb_d;
			o_op_test    <= test_d;
			o_op_mov     <= mov_d;
			o_op_in      <= in_d;
		end
	end

	// operand payload, only looked at when a destination flag is set
	always_ff @(posedge clk)
	begin
		o_alu_b <= src_dmem ? i_dmem_data : (is_i8 ? imm8 : imm3_ext);
		o_imm   <= imm8; // raw bits: stm address, setb pointer and side
	end

	// field pointer and its write-side copy FIELD_LATENCY edges later
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_fieldp <= '0;
			for (int i = 0; i < FIELD_LATENCY; i++)
				fieldp_hist[i] <= '0;
		end
		else
		begin
			o_fieldp       <= instr_d[F_FIELDP_MSB:F_FIELDP_LSB];
			fieldp_hist[0] <= o_fieldp;
			for (int i = 1; i < FIELD_LATENCY; i++)
				fieldp_hist[i] <= fieldp_hist[i-1]; // shift toward the write side
		end
	end

	assign o_fieldwp = fieldp_hist[FIELD_LATENCY-1];

endmodule

/* hdl/pat_pkg.sv */
package pat_pkg;

	// ============================================================
	// widths and sizes
	// ============================================================
	localparam int I_WIDTH        = 20; // instruction word
	localparam int D_WIDTH        = 8;  // acc, memory and field data
	localparam int PC_WIDTH       = 10;
	localparam int FIELDP_WIDTH   = 5;
	localparam int BUFP_WIDTH     = 3;
	localparam int DMEM_DEPTH     = 16;
	localparam int DMEM_ADR_WIDTH = 4;

	// ============================================================
	// instruction field layout
	// ============================================================
	localparam int F_FIELDP_MSB = 19; // next field pointer
	localparam int F_FIELDP_LSB = 15;
	localparam int F_COND_MSB   = 14;
	localparam int F_COND_LSB   = 13;
	localparam int F_FIELD_OP   = 12; // 1 selects field as operand / destination
	localparam int F_OP8_MSB    = 11;
	localparam int F_OP8_LSB    = 8;
	localparam int F_IMM_MSB    = 7;
	localparam int F_IMM_LSB    = 0;
	localparam int F_OP3_MSB    = 7;  // i3 opcode sits in the i8 immediate
	localparam int F_OP3_LSB    = 4;
	localparam int F_IMM3_MSB   = 2;
	localparam int F_IMM3_LSB   = 0;
	localparam int F_OP0_MSB    = 3;
	localparam int F_OP0_LSB    = 0;
	localparam int SETB_SIDE_BIT = 3; // setb: 1 = high side buffer

	localparam logic [3:0] PREFIX = 4'b1111; // escape to the next class
	localparam int FIELD_LATENCY = 4;        // fieldwp lags fieldp by this
	localparam logic [I_WIDTH-1:0] INSTR_NOP = 20'h00FFF; // i0 nop, cond always

	// ============================================================
	// opcodes and conditions
	// ============================================================
	typedef enum logic [3:0] {
		OP8_OR = 4'h0, OP8_AND = 4'h1, OP8_ADDM = 4'h2, OP8_SUBM = 4'h3,
		OP8_ADD = 4'h4, OP8_SUB = 4'h5, OP8_LDI = 4'h6, OP8_LDM = 4'h7,
		OP8_BF = 4'h8, OP8_STM = 4'hB, OP8_ORM = 4'hD, OP8_ANDM = 4'hE
	} op8_e;

	typedef enum logic [3:0] {
		OP3_SHL = 4'h0, OP3_SHLO = 4'h1, OP3_SHR = 4'h2, OP3_ASR = 4'h3,
		OP3_IN = 4'h5, OP3_OUT = 4'h8, OP3_SETB = 4'h9
	} op3_e;

	typedef enum logic [3:0] {
		OP0_NOT = 4'h0, OP0_MOV = 4'h1, OP0_TEST = 4'h2, OP0_NOP = 4'hF
	} op0_e;

	typedef enum logic [1:0] {
		COND_ALWAYS = 2'd0, COND_NEG = 2'd1, COND_ZERO = 2'd2, COND_ALWAYS_ALT = 2'd3
	} cond_e;

	typedef enum logic [3:0] {
		ALU_OR, ALU_AND, ALU_NOT, ALU_ADD, ALU_SUB,
		ALU_SHL, ALU_SHLO, ALU_SHR, ALU_ASR, ALU_PASS_B
	} alu_op_e;

endpackage

/* hdl/pat_program_counter.sv */
`timescale 1ns/1ps

module pat_program_counter import pat_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	input  logic                i_jump,    // bf in D stage
	input  logic [D_WIDTH-1:0]  i_offset,  // signed branch distance
	output logic [PC_WIDTH-1:0] o_pc
);

	logic [PC_WIDTH-1:0] offset_ext;

	// sign extend so negative offsets branch back
	assign offset_ext = {{(PC_WIDTH-D_WIDTH){i_offset[D_WIDTH-1]}}, i_offset};

	always_ff @(posedge clk)
	begin
		if (reset)
			o_pc <= '0;
		else if (i_jump)
			o_pc <= o_pc + offset_ext;
		else
			o_pc <= o_pc + PC_WIDTH'(1);
	end

endmodule

/* hdl/pat_top.sv */
`timescale 1ns/1ps

module pat_top import pat_pkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [I_WIDTH-1:0]      i_instruction,
	input  logic [D_WIDTH-1:0]      i_field_in_low,
	input  logic [D_WIDTH-1:0]      i_field_in_high,
	input  logic [D_WIDTH-1:0]      i_inputs,
	output logic [PC_WIDTH-1:0]     o_pc,
	output logic                    o_jump,
	output logic [BUFP_WIDTH-1:0]   o_bufp,
	output logic [FIELDP_WIDTH-1:0] o_fieldp,
	output logic [FIELDP_WIDTH-1:0] o_fieldwp,
	output logic                    o_field_we_low,
	output logic                    o_field_we_high,
	output logic [D_WIDTH-1:0]      o_field_out,
	output logic [D_WIDTH-1:0]      o_acc,
	output logic [D_WIDTH-1:0]      o_outputs
);

	logic [D_WIDTH-1:0]        branch_offset;
	logic [DMEM_ADR_WIDTH-1:0] dmem_radr, dmem_wadr;
	logic [D_WIDTH-1:0]        dmem_rdata, dmem_wdata;
	logic                      dmem_we;
	alu_op_e                   e_alu_op;
	logic [D_WIDTH-1:0]        e_alu_b, e_imm, alu_y;
	cond_e                     e_cond;
	logic                      e_field_op, e_dest_acc, e_dest_field, e_dest_dmem;
	logic                      e_op_out, e_op_setb, e_op_test, e_op_mov, e_op_in;
	logic                      high_sel;

	// ============================================================
	// ALU A operand, acc or the field input on the selected side
	// ============================================================
	wire [D_WIDTH-1:0] alu_a = e_field_op ? (high_sel ? i_field_in_high : i_field_in_low) : o_acc;

	pat_decode u_decode (
		.clk(clk), .reset(reset), .i_instruction(i_instruction), .i_dmem_data(dmem_rdata),
		.o_jump(o_jump), .o_branch_offset(branch_offset), .o_dmem_adr(dmem_radr),
		.o_alu_op(e_alu_op), .o_alu_b(e_alu_b), .o_cond(e_cond), .o_field_op(e_field_op),
		.o_dest_acc(e_dest_acc), .o_dest_field(e_dest_field), .o_dest_dmem(e_dest_dmem),
		.o_op_out(e_op_out), .o_op_setb(e_op_setb), .o_op_test(e_op_test),
		.o_op_mov(e_op_mov), .o_op_in(e_op_in), .o_imm(e_imm),
		.o_fieldp(o_fieldp), .o_fieldwp(o_fieldwp)
	);

	pat_alu u_alu (.i_a(alu_a), .i_b(e_alu_b), .i_alu_op(e_alu_op), .o_y(alu_y));

	pat_commit u_commit (
		.clk(clk), .reset(reset), .i_alu_y(alu_y), .i_cond(e_cond), .i_field_op(e_field_op),
		.i_dest_acc(e_dest_acc), .i_dest_field(e_dest_field), .i_dest_dmem(e_dest_dmem),
		.i_op_out(e_op_out), .i_op_setb(e_op_setb), .i_op_test(e_op_test),
		.i_op_mov(e_op_mov), .i_op_in(e_op_in), .i_imm(e_imm),
		.i_field_in_low(i_field_in_low), .i_field_in_high(i_field_in_high),
		.i_inputs(i_inputs), .o_acc(o_acc), .o_high_sel(high_sel),
		.o_dmem_we(dmem_we), .o_dmem_wadr(dmem_wadr), .o_dmem_wdata(dmem_wdata),
		.o_field_we_low(o_field_we_low), .o_field_we_high(o_field_we_high),
		.o_field_out(o_field_out), .o_outputs(o_outputs), .o_bufp(o_bufp)
	);

	pat_data_mem u_dmem (
		.clk(clk), .i_radr(dmem_radr), .o_rdata(dmem_rdata),
		.i_we(dmem_we), .i_wadr(dmem_wadr), .i_wdata(dmem_wdata)
	);

	pat_program_counter u_pc (
		.clk(clk), .reset(reset), .i_jump(o_jump), .i_offset(branch_offset), .o_pc(o_pc)
	);

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module pat_tb -f compile.f -o pat_tb_sim \
	&& ./obj_dir/pat_tb_sim \
	|| { echo "simulation build or run failed"; exit 1; }

/* testbench/pat_tb.sv */
`timescale 1ns/1ps

module pat_tb import pat_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int N_ALU      = 40; // random alu ops
	localparam int N_MEM      = 8;  // store and load rounds of 6 words
	localparam int N_COND     = 8;  // test and conditional rounds of 5 words
	localparam int N_FIELD    = 4;  // field rounds of 8 words
	localparam int N_BRANCH   = 6;  // bf + nop
	localparam int DRAIN_LEN  = 8;  // covers commit and fieldwp delay
	localparam int TOTAL_INSTR = N_ALU + 6 * N_MEM + 5 * N_COND + 8 * N_FIELD
		+ 2 * N_BRANCH + 5 * DRAIN_LEN;

	logic                    clk, reset;
	logic [I_WIDTH-1:0]      i_instruction;
	logic [D_WIDTH-1:0]      i_field_in_low, i_field_in_high, i_inputs;
	logic [PC_WIDTH-1:0]     o_pc;
	logic                    o_jump, o_field_we_low, o_field_we_high;
	logic [BUFP_WIDTH-1:0]   o_bufp;
	logic [FIELDP_WIDTH-1:0] o_fieldp, o_fieldwp;
	logic [D_WIDTH-1:0]      o_field_out, o_acc, o_outputs;

	integer seed = 15;

	// reference model state
	logic [I_WIDTH-1:0]    hist [$];              // every word issued so far
	logic [PC_WIDTH-1:0]   m_pc = '0;
	logic [D_WIDTH-1:0]    m_acc = '0, m_outputs = '0, m_field_out = '0;
	logic                  m_z = 1'b0, m_n = 1'b0, m_high = 1'b0;
	logic                  m_we_low = 1'b0, m_we_high = 1'b0;
	logic [BUFP_WIDTH-1:0] m_bufp = '0;
	logic [D_WIDTH-1:0]    m_mem [DMEM_DEPTH];
	logic [D_WIDTH-1:0]    seen_low = '0, seen_high = '0, seen_inputs = '0; // live at commit

	tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(3)) clock_gen_inst (
		.clk(clk), .reset(reset)
	);

	pat_top pat_top_inst (
		.clk(clk), .reset(reset), .i_instruction(i_instruction),
		.i_field_in_low(i_field_in_low), .i_field_in_high(i_field_in_high),
		.i_inputs(i_inputs), .o_pc(o_pc), .o_jump(o_jump), .o_bufp(o_bufp),
		.o_fieldp(o_fieldp), .o_fieldwp(o_fieldwp), .o_field_we_low(o_field_we_low),
		.o_field_we_high(o_field_we_high), .o_field_out(o_field_out),
		.o_acc(o_acc), .o_outputs(o_outputs)
	);

	// ============================================================
	// instruction encoding and small helpers
	// ============================================================
	function automatic logic [I_WIDTH-1:0] imm8_instr(input op8_e op, input logic [7:0] imm,
		input cond_e cond, input logic fb);
		return {5'b0, cond, fb, op, imm};
	endfunction

	function automatic logic [I_WIDTH-1:0] imm3_instr(input op3_e op, input logic [3:0] low,
		input cond_e cond, input logic fb);
		return {5'b0, cond, fb, PREFIX, op, low}; // low bit 3 is the setb side
	endfunction

	function automatic logic [I_WIDTH-1:0] bare_instr(input op0_e op, input cond_e cond,
		input logic fb);
		return {5'b0, cond, fb, PREFIX, PREFIX, op};
	endfunction

	function automatic logic [7:0] rand_byte();
		return 8'($random(seed));
	endfunction

	// word issued k steps ago or a nop before the first one
	function automatic logic [I_WIDTH-1:0] hist_at(input int k);
		int idx;
		idx = hist.size() - k;
		return (idx < 0) ? INSTR_NOP : hist[idx];
	endfunction

	function automatic logic is_bf(input logic [I_WIDTH-1:0] w);
		return w[F_OP8_MSB:F_OP8_LSB] == OP8_BF;
	endfunction

	// shifts move one bit per step
	function automatic logic [D_WIDTH-1:0] shift_ref(input op3_e op,
		input logic [D_WIDTH-1:0] a, input logic [2:0] s);
		logic [D_WIDTH-1:0] r;
		r = a;
		repeat (s)
		begin
			case (op)
				OP3_SHL:  r = {r[D_WIDTH-2:0], 1'b0};
				OP3_SHLO: r = {r[D_WIDTH-2:0], 1'b1};         // ones move in
				OP3_SHR:  r = {1'b0, r[D_WIDTH-1:1]};
				default:  r = {r[D_WIDTH-1], r[D_WIDTH-1:1]}; // asr keeps sign
			endcase
		end
		return r;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[FAIL] time=%0t %s expected=0x%0h actual=0x%0h", $time, name, expected, actual);
		$display("TEST RESULT: FAIL");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else report_mismatch(name, expected, actual);
	endtask

	// ============================================================
	// reference model for one committed word
	// ============================================================
	task automatic commit_ref(input logic [I_WIDTH-1:0] w);
		logic               fb, ok, has_res;
		logic [D_WIDTH-1:0] imm, fsel, a, res, mem_b;
		op8_e               op8;
		op3_e               op3;
		op0_e               op0;
		fb    = w[F_FIELD_OP];
		imm   = w[F_IMM_MSB:F_IMM_LSB];
		fsel  = m_high ? seen_high : seen_low;
		a     = fb ? fsel : m_acc;                 // field bit picks the A source
		mem_b = m_mem[imm[DMEM_ADR_WIDTH-1:0]];
		op8   = op8_e'(w[F_OP8_MSB:F_OP8_LSB]);
		op3   = op3_e'(w[F_OP3_MSB:F_OP3_LSB]);
		op0   = op0_e'(w[F_OP0_MSB:F_OP0_LSB]);
		case (w[F_COND_MSB:F_COND_LSB])
			2'd1:    ok = m_n;
			2'd2:    ok = m_z;
			default: ok = 1'b1;
		endcase
		m_we_low  = 1'b0;
		m_we_high = 1'b0;
		has_res   = 1'b0;
		res       = '0;
		if (w[F_OP8_MSB:F_OP8_LSB] != PREFIX)
		begin
			has_res = (op8 != OP8_STM) && (op8 != OP8_BF);
			case (op8)
				OP8_OR:   res = a | imm;
				OP8_AND:  res = a & imm;
				OP8_ADD:  res = a + imm;
				OP8_SUB:  res = a - imm;
				OP8_ORM:  res = a | mem_b;
				OP8_ANDM: res = a & mem_b;
				OP8_ADDM: res = a + mem_b;
				OP8_SUBM: res = a - mem_b;
				OP8_LDI:  res = imm;
				OP8_LDM:  res = mem_b;
				OP8_STM:
					if (ok)
						m_mem[imm[DMEM_ADR_WIDTH-1:0]] = fb ? fsel : m_acc;
				default:  ;                         // bf does nothing at commit
			endcase
		end
		else if (w[F_OP3_MSB:F_OP3_LSB] != PREFIX)
		begin
			case (op3)
				OP3_SHL, OP3_SHLO, OP3_SHR, OP3_ASR:
				begin
					res     = shift_ref(op3, a, w[2:0]);
					has_res = 1'b1;
				end
				OP3_IN:
				begin
					res     = seen_inputs;
					has_res = 1'b1;
				end
				OP3_OUT:
					if (ok)
						m_outputs = m_acc;
				OP3_SETB:
					if (ok)
					begin
						m_bufp = w[2:0];
						m_high = w[3];
					end
				default: ;
			endcase
		end
		else
		begin
			case (op0)
				OP0_NOT:
				begin
					res     = ~a;
					has_res = 1'b1;
				end
				OP0_MOV:
				begin
					res     = fb ? m_acc : fsel;        // direction set by field bit
					has_res = 1'b1;
				end
				OP0_TEST:
					if (ok)
					begin
						m_z = (a == '0);
						m_n = a[D_WIDTH-1];
					end
				default: ;                              // nop
			endcase
		end
		if (ok && has_res)
		begin
			if (fb)
			begin
				m_field_out = res;
				m_we_high   = m_high;
				m_we_low    = !m_high;
			end
			else
				m_acc = res;
		end
	endtask

	// ============================================================
	// update model for the edge just passed then check and drive
	// ============================================================
	task automatic step(input logic [I_WIDTH-1:0] instr);
		logic [I_WIDTH-1:0] w, in_d, prev2, prev6;
		w = instr;
		w[F_FIELDP_MSB:F_FIELDP_LSB] = FIELDP_WIDTH'($random(seed)); // random next fieldp
		prev2 = hist_at(2);
		if (hist.size() > 0)
		begin
			if (is_bf(prev2))
				m_pc = m_pc + PC_WIDTH'($signed(prev2[F_IMM_MSB:F_IMM_LSB]));
			else
				m_pc = m_pc + PC_WIDTH'(1);
			commit_ref(hist_at(3));
		end
		in_d  = hist_at(1);
		prev6 = hist_at(6);
		check_value("o_pc", 32'(m_pc), 32'(o_pc));
		check_value("o_jump", 32'(is_bf(in_d)), 32'(o_jump));
		check_value("o_fieldp", 32'(prev2[F_FIELDP_MSB:F_FIELDP_LSB]), 32'(o_fieldp));
		check_value("o_fieldwp", 32'(prev6[F_FIELDP_MSB:F_FIELDP_LSB]), 32'(o_fieldwp));
		check_value("o_acc", 32'(m_acc), 32'(o_acc));
		check_value("o_outputs", 32'(m_outputs), 32'(o_outputs));
		check_value("o_field_out", 32'(m_field_out), 32'(o_field_out));
		check_value("o_field_we_low", 32'(m_we_low), 32'(o_field_we_low));
		check_value("o_field_we_high", 32'(m_we_high), 32'(o_field_we_high));
		check_value("o_bufp", 32'(m_bufp), 32'(o_bufp));
		seen_low    = i_field_in_low;  // what the next commit edge sees
		seen_high   = i_field_in_high;
		seen_inputs = i_inputs;
		i_instruction = w;
		hist.push_back(w);
		@(posedge clk);
		#1;
	endtask

	task automatic drain();
		repeat (DRAIN_LEN) step(INSTR_NOP);
	endtask

	task automatic set_field_inputs(input logic [7:0] low, input logic [7:0] high,
		input logic [7:0] ins);
		i_field_in_low  = low;
		i_field_in_high = high;
		i_inputs        = ins;
	endtask

	// ============================================================
	// tests
	// ============================================================
	task automatic alu_random_ops();
		logic [7:0] v;
		int         pick;
		for (int i = 0; i < N_ALU; i++)
		begin
			v    = rand_byte();
			pick = (i == 0) ? 0 : int'(rand_byte() % 8'd10);
			case (pick)
				0: step(imm8_instr(OP8_LDI, v, COND_ALWAYS, 1'b0));
				1: step(imm8_instr(OP8_ADD, v, COND_ALWAYS, 1'b0));
				2: step(imm8_instr(OP8_SUB, v, COND_ALWAYS, 1'b0));
				3: step(imm8_instr(OP8_OR, v, COND_ALWAYS, 1'b0));
				4: step(imm8_instr(OP8_AND, v, COND_ALWAYS, 1'b0));
				5: step(bare_instr(OP0_NOT, COND_ALWAYS, 1'b0));
				6: step(imm3_instr(OP3_SHL, v[3:0], COND_ALWAYS, 1'b0));
				7: step(imm3_instr(OP3_SHLO, v[3:0], COND_ALWAYS, 1'b0));
				8: step(imm3_instr(OP3_SHR, v[3:0], COND_ALWAYS, 1'b0));
				default: step(imm3_instr(OP3_ASR, v[3:0], COND_ALWAYS, 1'b0));
			endcase
		end
		drain();
	endtask

	task automatic memory_roundtrip();
		logic [7:0] adr;
		op8_e       mop;
		set_field_inputs(rand_byte(), rand_byte(), rand_byte());
		for (int r = 0; r < N_MEM; r++)
		begin
			adr = rand_byte() % 8'd16;
			case (r % 5)
				0:       mop = OP8_LDM;
				1:       mop = OP8_ADDM;
				2:       mop = OP8_SUBM;
				3:       mop = OP8_ORM;
				default: mop = OP8_ANDM;
			endcase
			step(imm8_instr(OP8_LDI, rand_byte(), COND_ALWAYS, 1'b0));
			step(imm8_instr(OP8_STM, adr, COND_ALWAYS, 1'(r % 2))); // odd rounds store field
			step(INSTR_NOP);
			step(INSTR_NOP);
			step(imm8_instr(OP8_LDI, rand_byte(), COND_ALWAYS, 1'b0));
			step(imm8_instr(mop, adr, COND_ALWAYS, 1'b0));
		end
		drain();
	endtask

	task automatic conditional_commits();
		logic [7:0] v;
		for (int r = 0; r < N_COND; r++)
		begin
			v = (r % 3 == 0) ? 8'h00 : rand_byte(); // some zeros for the z flag
			step(imm8_instr(OP8_LDI, v, COND_ALWAYS, 1'b0));
			step(bare_instr(OP0_TEST, COND_ALWAYS, 1'b0));
			step(imm8_instr(OP8_ADD, 8'h01, COND_NEG, 1'b0));
			step(imm8_instr(OP8_ADD, 8'h02, COND_ZERO, 1'b0));
			step(imm8_instr(OP8_ADD, 8'h04, COND_ALWAYS_ALT, 1'b0));
		end
		drain();
	endtask

	task automatic field_port_ops();
		for (int r = 0; r < N_FIELD; r++)
		begin
			set_field_inputs(rand_byte(), rand_byte(), rand_byte());
			step(imm3_instr(OP3_SETB, {1'(r % 2), 3'(rand_byte())}, COND_ALWAYS, 1'b0));
			step(imm8_instr(OP8_ADD, rand_byte(), COND_ALWAYS, 1'b1));
			step(bare_instr(OP0_NOT, COND_ALWAYS, 1'b1));
			step(imm3_instr(OP3_SHR, 4'(rand_byte()), COND_ALWAYS, 1'b1));
			step(bare_instr(OP0_MOV, COND_ALWAYS, 1'b0)); // acc from field input
			step(imm3_instr(OP3_OUT, 4'h0, COND_ALWAYS, 1'b0));
			step(bare_instr(OP0_MOV, COND_ALWAYS, 1'b1)); // field out from acc
			step(imm3_instr(OP3_IN, 4'h0, COND_ALWAYS, 1'b0));
		end
		drain();
	endtask

	task automatic branch_offsets();
		logic [7:0] off;
		for (int r = 0; r < N_BRANCH; r++)
		begin
			off    = rand_byte();
			off[7] = 1'(r % 2);                        // alternate forward and back
			step(imm8_instr(OP8_BF, off, COND_ALWAYS, 1'b0));
			step(INSTR_NOP);
		end
		drain();
	endtask

	// watchdog sized from the instruction count
	initial
	begin
		#((TOTAL_INSTR + 20) * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog timeout");
	end

	initial
	begin
		i_instruction = INSTR_NOP;
		set_field_inputs(8'h00, 8'h00, 8'h00);
		@(negedge reset);                          // released 1 ns after an edge
		alu_random_ops();
		memory_roundtrip();
		conditional_commits();
		field_port_ops();
		branch_offsets();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// reset held over the first edges, dropped just after the last one
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0;
	end

endmodule
